/* src/dnc_write_pkg.sv */
// Shared types for the DNC write-head parameter stage.
// Imported by every RTL module and by the testbench.
`default_nettype none

package dnc_write_pkg;

  // Signed fixed-point word, fraction width set per module
  typedef logic signed [31:0] fix_t;

  // APB request from the host
  typedef struct packed {
    logic [7:0]  paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] pwdata;
  } apb_req_t;

  // APB response back to the host
  typedef struct packed {
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
  } apb_rsp_t;

  // Register offsets
  typedef enum logic [7:0] {
    REG_CTRL         = 8'h00,
    REG_BETA_IN      = 8'h04,
    REG_GATE_IN      = 8'h08,
    REG_BETA_OUT     = 8'h0C,
    REG_GATE_OUT     = 8'h10,
    REG_STRENGTH_OUT = 8'h14
  } reg_addr_e;

  // Operation controller
  typedef enum logic {
    IDLE,
    BUSY
  } ctrl_state_e;

  // Result record, 96 bits
  typedef struct packed {
    fix_t beta;
    fix_t gate;
    fix_t gated_strength;
  } head_params_t;

endpackage

`default_nettype wire

/* src/dnc_apb_regs.sv */
// APB register block: operands, control and results of the write head.
// Issues one start pulse per operation and captures the result record on done.
`default_nettype none

module dnc_apb_regs (
  input  logic                        clk,
  input  logic                        rst_n,
  input  dnc_write_pkg::apb_req_t     apb_req,
  output dnc_write_pkg::apb_rsp_t     apb_rsp,
  output logic                        start,
  output dnc_write_pkg::fix_t         beta_in,
  output dnc_write_pkg::fix_t         gate_in,
  input  logic                        done,
  input  dnc_write_pkg::head_params_t params
);
  import dnc_write_pkg::*;

  //////////////////////////////////////////////////////////////////////
  // Address decode
  //////////////////////////////////////////////////////////////////////

  ctrl_state_e  state;
  head_params_t params_q;
  logic         done_q;
  logic         busy;
  logic         access;
  logic         addr_ok;
  logic         read_only;
  logic         err;
  logic         wr_ok;
  logic         start_req;
  logic [31:0]  rdata;

  // Zero wait states, the access phase completes the transfer
  assign access = apb_req.psel & apb_req.penable;
  assign busy   = (state == BUSY);

  always_comb begin
    addr_ok   = 1'b1;
    read_only = 1'b0;
    rdata     = '0;
    case (apb_req.paddr)
      REG_CTRL:         rdata = {30'd0, done_q, busy};
      REG_BETA_IN:      rdata = beta_in;
      REG_GATE_IN:      rdata = gate_in;
      REG_BETA_OUT: begin
        rdata     = params_q.beta;
        read_only = 1'b1;
      end
      REG_GATE_OUT: begin
        rdata     = params_q.gate;
        read_only = 1'b1;
      end
      REG_STRENGTH_OUT: begin
        rdata     = params_q.gated_strength;
        read_only = 1'b1;
      end
      default:          addr_ok = 1'b0;
    endcase
  end

  // Unmapped offset, or a write into a result register
  assign err       = ~addr_ok | (apb_req.pwrite & read_only);
  assign wr_ok     = access & apb_req.pwrite & ~err;
  // Start while busy is dropped without an error
  assign start_req = wr_ok & (apb_req.paddr == REG_CTRL) & apb_req.pwdata[0] & ~busy;

  assign apb_rsp.prdata  = rdata;
  assign apb_rsp.pready  = 1'b1;
  assign apb_rsp.pslverr = apb_req.psel & err;

  //////////////////////////////////////////////////////////////////////
  // Operand registers
  //////////////////////////////////////////////////////////////////////

  // Units latch on start, so writes here during BUSY hit the next run
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      beta_in <= '0;
      gate_in <= '0;
    end else if (wr_ok) begin
      if (apb_req.paddr == REG_BETA_IN)
        beta_in <= apb_req.pwdata;
      if (apb_req.paddr == REG_GATE_IN)
        gate_in <= apb_req.pwdata;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Controller and result capture
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= IDLE;
      start    <= 1'b0;
      done_q   <= 1'b0;
      params_q <= '0;
    end else begin
      // Single-cycle pulse
      start <= 1'b0;
      case (state)
        IDLE: begin
          if (start_req) begin
            state  <= BUSY;
            start  <= 1'b1;
            // Sticky done clears on the new operation
            done_q <= 1'b0;
          end
        end
        BUSY: begin
          if (done) begin
            state    <= IDLE;
            params_q <= params;
            done_q   <= 1'b1;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

/* src/dnc_write_strength.sv */
// Write strength unit, beta = oneplus(beta^) = 1 + softplus(beta^).
// Two register stages, ready pulses two cycles after start.
`default_nettype none

module dnc_write_strength #(
  parameter int FRAC_BITS = 16
) (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                start,
  input  dnc_write_pkg::fix_t beta_in,
  output logic                ready,
  output dnc_write_pkg::fix_t beta
);
  import dnc_write_pkg::*;

  localparam fix_t ONE = fix_t'(1) <<< FRAC_BITS;
  localparam fix_t TWO = fix_t'(2) <<< FRAC_BITS;

  // Piecewise softplus regions
  typedef enum logic [1:0] {
    RGN_LOW,
    RGN_MID,
    RGN_HIGH
  } region_e;

  fix_t               shifted;
  logic signed [63:0] sq_d;
  region_e            rgn_d;
  fix_t               x_q;
  region_e            rgn_q;
  logic signed [63:0] sq_q;
  logic               valid_q;
  fix_t               softplus;

  // Stage 1 classify, square of (x+2) in the middle region
  always_comb begin
    shifted = beta_in + TWO;
    sq_d    = '0;
    if (beta_in <= -TWO) begin
      rgn_d = RGN_LOW;
    end else if (beta_in >= TWO) begin
      rgn_d = RGN_HIGH;
    end else begin
      rgn_d = RGN_MID;
      // Full 64-bit product, 2*FRAC_BITS fraction bits
      sq_d  = shifted * shifted;
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      x_q   <= beta_in;
      rgn_q <= rgn_d;
      sq_q  <= sq_d;
    end
  end

  // Stage 2 divide by 8 and drop FRAC_BITS in one floor shift
  always_comb begin
    case (rgn_q)
      RGN_MID:  softplus = fix_t'(sq_q >>> (FRAC_BITS + 3));
      RGN_HIGH: softplus = x_q;
      default:  softplus = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (valid_q)
      beta <= softplus + ONE;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
      ready   <= 1'b0;
    end else begin
      valid_q <= start;
      ready   <= valid_q;
    end
  end

endmodule

`default_nettype wire

/* src/dnc_write_gate.sv */
// Write gate unit, g = hard sigmoid(g^).
// One register stage, ready pulses one cycle after start.
`default_nettype none

module dnc_write_gate #(
  parameter int FRAC_BITS = 16
) (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                start,
  input  dnc_write_pkg::fix_t gate_in,
  output logic                ready,
  output dnc_write_pkg::fix_t gate
);
  import dnc_write_pkg::*;

  localparam fix_t ONE  = fix_t'(1) <<< FRAC_BITS;
  localparam fix_t TWO  = fix_t'(2) <<< FRAC_BITS;
  localparam fix_t HALF = fix_t'(1) <<< (FRAC_BITS - 1);

  fix_t gate_d;

  // Clamp outside [-2, 2], linear slope 1/4 inside
  always_comb begin
    if (gate_in <= -TWO)
      gate_d = '0;
    else if (gate_in >= TWO)
      gate_d = ONE;
    else
      gate_d = HALF + (gate_in >>> 2);
  end

  // Operand taken on start only
  always_ff @(posedge clk) begin
    if (start)
      gate <= gate_d;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      ready <= 1'b0;
    else
      ready <= start;
  end

endmodule

`default_nettype wire

/* src/dnc_write_combine.sv */
// Joins beta and g once both units have answered and forms g*beta.
// Done pulses one cycle after the later of the two ready pulses.
`default_nettype none

module dnc_write_combine #(
  parameter int FRAC_BITS = 16
) (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        strength_ready,
  input  dnc_write_pkg::fix_t         beta,
  input  logic                        gate_ready,
  input  dnc_write_pkg::fix_t         gate,
  output logic                        done,
  output dnc_write_pkg::head_params_t params
);
  import dnc_write_pkg::*;

  fix_t               beta_q;
  fix_t               gate_q;
  fix_t               beta_cur;
  fix_t               gate_cur;
  logic               have_beta;
  logic               have_gate;
  logic               beta_avail;
  logic               gate_avail;
  logic               both;
  logic signed [63:0] product;

  // Bypass the latch on the ready cycle itself
  always_comb begin
    beta_cur   = strength_ready ? beta : beta_q;
    gate_cur   = gate_ready ? gate : gate_q;
    beta_avail = strength_ready | have_beta;
    gate_avail = gate_ready | have_gate;
    both       = beta_avail & gate_avail;
    product    = gate_cur * beta_cur;
  end

  always_ff @(posedge clk) begin
    if (strength_ready)
      beta_q <= beta;
    if (gate_ready)
      gate_q <= gate;
    // Gated strength keeps FRAC_BITS after a floor shift
    if (both)
      params <= '{beta: beta_cur,
                  gate: gate_cur,
                  gated_strength: fix_t'(product >>> FRAC_BITS)};
  end

  // Arrival flags clear when the record goes out
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      have_beta <= 1'b0;
      have_gate <= 1'b0;
      done      <= 1'b0;
    end else begin
      have_beta <= beta_avail & ~both;
      have_gate <= gate_avail & ~both;
      done      <= both;
    end
  end

endmodule

`default_nettype wire

/* src/dnc_write_head.sv */
// Top of the DNC write-head parameter stage, reached only over APB.
// FRAC_BITS sets the fraction width of every fixed-point word.
`default_nettype none

module dnc_write_head #(
  parameter int FRAC_BITS = 16
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  dnc_write_pkg::apb_req_t apb_req,
  output dnc_write_pkg::apb_rsp_t apb_rsp
);
  import dnc_write_pkg::*;

  logic         start;
  fix_t         beta_in;
  fix_t         gate_in;
  logic         strength_ready;
  fix_t         beta;
  logic         gate_ready;
  fix_t         gate;
  logic         done;
  head_params_t params;

  //////////////////////////////////////////////////////////////////////
  // Host side
  //////////////////////////////////////////////////////////////////////

  dnc_apb_regs u_regs (
    .clk     (clk),
    .rst_n   (rst_n),
    .apb_req (apb_req),
    .apb_rsp (apb_rsp),
    .start   (start),
    .beta_in (beta_in),
    .gate_in (gate_in),
    .done    (done),
    .params  (params)
  );

  //////////////////////////////////////////////////////////////////////
  // Parameter units, both started together
  //////////////////////////////////////////////////////////////////////

  dnc_write_strength #(.FRAC_BITS(FRAC_BITS)) u_strength (
    .clk     (clk),
    .rst_n   (rst_n),
    .start   (start),
    .beta_in (beta_in),
    .ready   (strength_ready),
    .beta    (beta)
  );

  dnc_write_gate #(.FRAC_BITS(FRAC_BITS)) u_gate (
    .clk     (clk),
    .rst_n   (rst_n),
    .start   (start),
    .gate_in (gate_in),
    .ready   (gate_ready),
    .gate    (gate)
  );

  // Result record back to the register block
  dnc_write_combine #(.FRAC_BITS(FRAC_BITS)) u_combine (
    .clk            (clk),
    .rst_n          (rst_n),
    .strength_ready (strength_ready),
    .beta           (beta),
    .gate_ready     (gate_ready),
    .gate           (gate),
    .done           (done),
    .params         (params)
  );

endmodule

`default_nettype wire

/* test/dnc_write_head_props.sv */
// Protocol and control assertions for the APB register block.
// Bound into dnc_apb_regs, failures show up as assertion errors.
`default_nettype none

module dnc_write_head_props (
  input logic clk,
  input logic rst_n,
  input logic start,
  input logic busy,
  input logic done,
  input logic pready
);
  timeunit 1ns;
  timeprecision 100ps;

  // Start is a single-cycle pulse
  assert property (@(posedge clk) disable iff (!rst_n) start |=> !start)
    else $error("start held for more than one cycle");

  // A run only begins from IDLE
  assert property (@(posedge clk) disable iff (!rst_n) start |-> !$past(busy))
    else $error("start issued while the controller was busy");

  // Zero wait states
  assert property (@(posedge clk) disable iff (!rst_n) pready)
    else $error("pready dropped low");

  // Done only comes back during a run
  assert property (@(posedge clk) disable iff (!rst_n) done |-> busy)
    else $error("done arrived while the controller was idle");

  // Controller leaves BUSY right after done
  assert property (@(posedge clk) disable iff (!rst_n) done |=> !busy)
    else $error("busy still high the cycle after done");

endmodule

bind dnc_apb_regs dnc_write_head_props u_props (
  .clk    (clk),
  .rst_n  (rst_n),
  .start  (start),
  .busy   (busy),
  .done   (done),
  .pready (apb_rsp.pready)
);

`default_nettype wire

/* test/dnc_write_head_tb.sv */
// Testbench for the DNC write head, driven only through APB.
// Random and boundary operands checked against a fixed-point model.
`default_nettype none

module dnc_write_head_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import dnc_write_pkg::*;

  localparam int   FRAC_BITS   = 16;
  localparam int   NUM_OPS     = 300;
  localparam int   CYCLE_LIMIT = NUM_OPS * 16 + 200;
  localparam fix_t TWO         = fix_t'(32'sd2 <<< FRAC_BITS);

  logic        clk = 1'b0;
  logic        rst_n;
  apb_req_t    apb_req;
  apb_rsp_t    apb_rsp;
  logic [31:0] rng_state = 32'h1a84bc4a;
  int          cycles = 0;

  dnc_write_head #(.FRAC_BITS(FRAC_BITS)) dut (
    .clk     (clk),
    .rst_n   (rst_n),
    .apb_req (apb_req),
    .apb_rsp (apb_rsp)
  );

  // 8 ns clock
  always #4 clk = ~clk;

  // Run limit
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Done: errors found");
      $fatal(1);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus source and reference model
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  // Mostly within +-4.0, one in sixteen over the full range
  function automatic fix_t draw_operand();
    logic [31:0] sel;
    logic [31:0] raw;
    sel = next_rand();
    raw = next_rand();
    if (sel[3:0] == 4'd0)
      return fix_t'(raw);
    return fix_t'($signed(raw) >>> (29 - FRAC_BITS));
  endfunction

  // oneplus(x) with the piecewise softplus, wraps to 32 bits
  function automatic fix_t softplus_one(fix_t x);
    longint one_l;
    longint xl;
    longint t;
    longint sp;
    one_l = longint'(1) << FRAC_BITS;
    xl    = longint'(x);
    if (xl <= -2 * one_l) begin
      sp = 0;
    end else if (xl >= 2 * one_l) begin
      sp = xl;
    end else begin
      t  = xl + 2 * one_l;
      // (x+2)^2/8, floor on the way down
      sp = (t * t) >>> (FRAC_BITS + 3);
    end
    return fix_t'(sp + one_l);
  endfunction

  function automatic fix_t hard_sigmoid(fix_t x);
    longint one_l;
    longint xl;
    one_l = longint'(1) << FRAC_BITS;
    xl    = longint'(x);
    if (xl <= -2 * one_l)
      return '0;
    if (xl >= 2 * one_l)
      return fix_t'(one_l);
    return fix_t'(one_l / 2 + (xl >>> 2));
  endfunction

  function automatic fix_t gated_product(fix_t g, fix_t b);
    return fix_t'((longint'(g) * longint'(b)) >>> FRAC_BITS);
  endfunction

  function automatic logic [7:0] map_addr(int i);
    case (i)
      0:       return REG_CTRL;
      1:       return REG_BETA_IN;
      2:       return REG_GATE_IN;
      3:       return REG_BETA_OUT;
      4:       return REG_GATE_OUT;
      default: return REG_STRENGTH_OUT;
    endcase
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Compare tasks and APB driver
  //////////////////////////////////////////////////////////////////////

  task automatic report_failure();
    $display("Done: errors found");
    $fatal(1);
  endtask

  task automatic check_fix(string name, fix_t got, fix_t exp);
    if (got !== exp) begin
      $display("Error at %0t ns: %s got %h expected %h", $time, name, got, exp);
      report_failure();
    end
  endtask

  task automatic check_rsp(apb_rsp_t rsp, logic exp_err);
    if (rsp.pready !== 1'b1) begin
      $display("Error at %0t ns: pready got %b expected 1", $time, rsp.pready);
      report_failure();
    end
    if (rsp.pslverr !== exp_err) begin
      $display("Error at %0t ns: pslverr got %b expected %b", $time, rsp.pslverr, exp_err);
      report_failure();
    end
  endtask

  // Entered and left 1 ns after a rising edge
  task automatic write_reg(logic [7:0] addr, logic [31:0] data, logic exp_err);
    apb_req.paddr   = addr;
    apb_req.pwrite  = 1'b1;
    apb_req.pwdata  = data;
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    @(posedge clk);
    #1 apb_req.penable = 1'b1;
    #2 check_rsp(apb_rsp, exp_err);
    @(posedge clk);
    #1 apb_req.psel = 1'b0;
    apb_req.penable = 1'b0;
  endtask

  task automatic read_reg(logic [7:0] addr, logic exp_err, output logic [31:0] data);
    apb_req.paddr   = addr;
    apb_req.pwrite  = 1'b0;
    apb_req.pwdata  = '0;
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    @(posedge clk);
    #1 apb_req.penable = 1'b1;
    #2 check_rsp(apb_rsp, exp_err);
    data = apb_rsp.prdata;
    @(posedge clk);
    #1 apb_req.psel = 1'b0;
    apb_req.penable = 1'b0;
  endtask

  // Poll status until the sticky done bit is set
  task automatic wait_done();
    logic [31:0] status;
    status = '0;
    while (status[1] !== 1'b1)
      read_reg(REG_CTRL, 1'b0, status);
  endtask

  task automatic check_results(fix_t b, fix_t g);
    fix_t        exp_b;
    fix_t        exp_g;
    logic [31:0] data;
    exp_b = softplus_one(b);
    exp_g = hard_sigmoid(g);
    read_reg(REG_BETA_OUT, 1'b0, data);
    check_fix("beta_out", fix_t'(data), exp_b);
    read_reg(REG_GATE_OUT, 1'b0, data);
    check_fix("gate_out", fix_t'(data), exp_g);
    read_reg(REG_STRENGTH_OUT, 1'b0, data);
    check_fix("strength_out", fix_t'(data), gated_product(exp_g, exp_b));
  endtask

  task automatic run_op(fix_t b, fix_t g);
    write_reg(REG_BETA_IN, b, 1'b0);
    write_reg(REG_GATE_IN, g, 1'b0);
    write_reg(REG_CTRL, 32'h1, 1'b0);
    wait_done();
    check_results(b, g);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    fix_t        b;
    fix_t        g;
    fix_t        nb;
    fix_t        ng;
    logic [31:0] data;
    fix_t        saved [0:5];
    fix_t        edges [0:4];
    apb_req = '0;
    rst_n   = 1'b0;
    repeat (8) @(posedge clk);
    #1 rst_n = 1'b1;

    // Everything reads zero out of reset
    for (int i = 0; i < 6; i++) begin
      read_reg(map_addr(i), 1'b0, data);
      check_fix("reset_value", fix_t'(data), '0);
    end

    // Region edges and extremes
    edges[0] = -TWO;
    edges[1] = TWO;
    edges[2] = '0;
    edges[3] = fix_t'(32'h8000_0000);
    edges[4] = fix_t'(32'h7fff_ffff);
    for (int i = 0; i < 5; i++) begin
      run_op(edges[i], edges[i]);
      run_op(edges[i], edges[4 - i]);
    end
    // 1.5, 0.5 and 0.75 exactly
    run_op('0, '0);
    read_reg(REG_BETA_OUT, 1'b0, data);
    check_fix("beta_out", fix_t'(data), 32'sh0001_8000);
    read_reg(REG_GATE_OUT, 1'b0, data);
    check_fix("gate_out", fix_t'(data), 32'sh0000_8000);
    read_reg(REG_STRENGTH_OUT, 1'b0, data);
    check_fix("strength_out", fix_t'(data), 32'sh0000_c000);

    // Second start while busy is dropped, new operand waits for the next run
    b  = draw_operand();
    g  = draw_operand();
    nb = draw_operand();
    write_reg(REG_BETA_IN, b, 1'b0);
    write_reg(REG_GATE_IN, g, 1'b0);
    write_reg(REG_CTRL, 32'h1, 1'b0);
    write_reg(REG_CTRL, 32'h1, 1'b0);
    write_reg(REG_BETA_IN, nb, 1'b0);
    wait_done();
    check_results(b, g);
    repeat (3) begin
      read_reg(REG_CTRL, 1'b0, data);
      check_fix("ctrl_status", fix_t'(data), 32'sh2);
    end
    write_reg(REG_CTRL, 32'h1, 1'b0);
    wait_done();
    check_results(nb, g);

    // Register view left by the last run
    saved[0] = 32'sh2;
    saved[1] = nb;
    saved[2] = g;
    saved[3] = softplus_one(nb);
    saved[4] = hard_sigmoid(g);
    saved[5] = gated_product(saved[4], saved[3]);

    // Bad accesses flag pslverr and change nothing
    read_reg(8'h18, 1'b1, data);
    read_reg(8'hfc, 1'b1, data);
    write_reg(8'h20, 32'h1, 1'b1);
    write_reg(8'h02, 32'h1, 1'b1);
    write_reg(REG_BETA_OUT, 32'h1234_5678, 1'b1);
    write_reg(REG_GATE_OUT, 32'h1234_5678, 1'b1);
    write_reg(REG_STRENGTH_OUT, 32'h1234_5678, 1'b1);
    for (int i = 0; i < 6; i++) begin
      read_reg(map_addr(i), 1'b0, data);
      check_fix("after_bad_access", fix_t'(data), saved[i]);
    end

    // Status per cycle, busy for 4 cycles then done
    b = draw_operand();
    g = draw_operand();
    write_reg(REG_BETA_IN, b, 1'b0);
    write_reg(REG_GATE_IN, g, 1'b0);
    write_reg(REG_CTRL, 32'h1, 1'b0);
    apb_req.paddr  = REG_CTRL;
    apb_req.pwrite = 1'b0;
    apb_req.psel   = 1'b1;
    for (int k = 0; k < 5; k++) begin
      #2 check_rsp(apb_rsp, 1'b0);
      check_fix("ctrl_status", fix_t'(apb_rsp.prdata), (k < 4) ? 32'sh1 : 32'sh2);
      @(posedge clk);
      #1 apb_req.penable = ~apb_req.penable;
    end
    apb_req.psel    = 1'b0;
    apb_req.penable = 1'b0;
    check_results(b, g);

    // Random runs, next operands written while the current one is busy
    nb = draw_operand();
    ng = draw_operand();
    write_reg(REG_BETA_IN, nb, 1'b0);
    write_reg(REG_GATE_IN, ng, 1'b0);
    for (int i = 0; i < NUM_OPS; i++) begin
      b = nb;
      g = ng;
      write_reg(REG_CTRL, 32'h1, 1'b0);
      nb = draw_operand();
      ng = draw_operand();
      write_reg(REG_BETA_IN, nb, 1'b0);
      write_reg(REG_GATE_IN, ng, 1'b0);
      wait_done();
      check_results(b, g);
    end

    $display("Done: no errors");
    $finish;
  end

endmodule

`default_nettype wire

/* dnc_write_head.f */
src/dnc_write_pkg.sv
src/dnc_apb_regs.sv
src/dnc_write_strength.sv
src/dnc_write_gate.sv
src/dnc_write_combine.sv
src/dnc_write_head.sv
test/dnc_write_head_props.sv
test/dnc_write_head_tb.sv

/* Makefile */
# Verilator flow for the DNC write-head parameter stage
# make lint | make sim | make clean

TOP := dnc_write_head_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --timescale 1ns/100ps -Wall \
		--top-module $(TOP) -f dnc_write_head.f

sim:
	verilator --binary --timing --assert --timescale 1ns/100ps -Wno-fatal \
		--top-module $(TOP) -f dnc_write_head.f -o sim_$(TOP)
	./obj_dir/sim_$(TOP)

clean:
	rm -rf obj_dir
